// File: common/csr_pkg.sv
// data width, CSR addresses, bit positions, operation and index enums, pipeline structs
package csr_pkg;

  localparam int XLEN = 64;

  // architectural addresses
  localparam logic [11:0] CSR_ADDR_MCYCLE   = 12'hB00;
  localparam logic [11:0] CSR_ADDR_MSTATUS  = 12'h300;
  localparam logic [11:0] CSR_ADDR_MIE      = 12'h304;
  localparam logic [11:0] CSR_ADDR_MTVEC    = 12'h305;
  localparam logic [11:0] CSR_ADDR_MSCRATCH = 12'h340;
  localparam logic [11:0] CSR_ADDR_MEPC     = 12'h341;
  localparam logic [11:0] CSR_ADDR_MCAUSE   = 12'h342;
  localparam logic [11:0] CSR_ADDR_MIP      = 12'h344;

  // MPP = machine mode
  localparam logic [XLEN-1:0] MSTATUS_RESET = 64'h1800;

  localparam int MSTATUS_MIE_BIT  = 3;
  localparam int MSTATUS_MPIE_BIT = 7;
  localparam int MSTATUS_FS_LSB   = 13;
  localparam int MSTATUS_XS_LSB   = 15;
  localparam int MIE_MTIE_BIT     = 7;

  // encoded as funct3[1:0]
  typedef enum logic [1:0] {
    CSR_RW = 2'd1,
    CSR_RS = 2'd2,
    CSR_RC = 2'd3
  } csr_op_e;

  typedef enum logic [3:0] {
    CSR_IDX_MCYCLE   = 4'd0,
    CSR_IDX_MSTATUS  = 4'd1,
    CSR_IDX_MIE      = 4'd2,
    CSR_IDX_MTVEC    = 4'd3,
    CSR_IDX_MSCRATCH = 4'd4,
    CSR_IDX_MEPC     = 4'd5,
    CSR_IDX_MCAUSE   = 4'd6,
    CSR_IDX_MIP      = 4'd7,
    CSR_IDX_NONE     = 4'd8
  } csr_idx_e;

  typedef struct packed {
    logic            valid;
    logic [2:0]      funct3;
    logic [4:0]      rs1;
    logic [XLEN-1:0] rs1_val;
    logic [4:0]      rd;
    logic [11:0]     addr;
  } csr_req_t;

  typedef struct packed {
    logic            valid;
    csr_op_e         op;
    csr_idx_e        idx;
    logic [XLEN-1:0] operand;
    logic            do_write;
    logic [4:0]      rd;
    logic            illegal;
  } csr_dec_t;

  typedef struct packed {
    logic            valid;
    logic [4:0]      rd;
    logic [XLEN-1:0] data;
    logic            illegal;
  } csr_wb_t;

  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] cause;
  } trap_t;

endpackage

// File: csr_file/csr_file.sv
// csr_file: machine CSR storage, mcycle counter, mstatus SD bit, trap entry, interrupt enables
`timescale 1ns/1ns

module csr_file (
  input  logic                         clk,
  input  logic                         rst,
  input  csr_pkg::csr_idx_e            i_rd_idx,
  output logic [csr_pkg::XLEN-1:0]     o_rd_data,
  input  logic                         i_wr_en,
  input  csr_pkg::csr_idx_e            i_wr_idx,
  input  logic [csr_pkg::XLEN-1:0]     i_wr_data,
  input  csr_pkg::trap_t               i_trap,
  output logic [csr_pkg::XLEN-1:0]     o_trap_pc,
  output logic                         o_mstatus_mie,
  output logic                         o_mie_mtie
);

  logic [csr_pkg::XLEN-1:0] mcycle;
  logic [csr_pkg::XLEN-1:0] mstatus;
  logic [csr_pkg::XLEN-1:0] mie;
  logic [csr_pkg::XLEN-1:0] mtvec;
  logic [csr_pkg::XLEN-1:0] mscratch;
  logic [csr_pkg::XLEN-1:0] mepc;
  logic [csr_pkg::XLEN-1:0] mcause;
  logic [csr_pkg::XLEN-1:0] mip;

  logic                     mstatus_sd;
  logic [csr_pkg::XLEN-1:0] mstatus_wr;
  logic [csr_pkg::XLEN-1:0] mstatus_trap;

  always_comb begin
    case (i_rd_idx)
      csr_pkg::CSR_IDX_MCYCLE:   o_rd_data = mcycle;
      csr_pkg::CSR_IDX_MSTATUS:  o_rd_data = mstatus;
      csr_pkg::CSR_IDX_MIE:      o_rd_data = mie;
      csr_pkg::CSR_IDX_MTVEC:    o_rd_data = mtvec;
      csr_pkg::CSR_IDX_MSCRATCH: o_rd_data = mscratch;
      csr_pkg::CSR_IDX_MEPC:     o_rd_data = mepc;
      csr_pkg::CSR_IDX_MCAUSE:   o_rd_data = mcause;
      csr_pkg::CSR_IDX_MIP:      o_rd_data = mip;
      default:                   o_rd_data = '0;
    endcase
  end

  // SD summarises dirty FS or XS
  assign mstatus_sd = (i_wr_data[csr_pkg::MSTATUS_FS_LSB +: 2] == 2'b11) ||
                      (i_wr_data[csr_pkg::MSTATUS_XS_LSB +: 2] == 2'b11);
  assign mstatus_wr = {mstatus_sd, i_wr_data[csr_pkg::XLEN-2:0]};

  always_comb begin
    mstatus_trap                            = mstatus;
    mstatus_trap[csr_pkg::MSTATUS_MPIE_BIT] = mstatus[csr_pkg::MSTATUS_MIE_BIT];
    mstatus_trap[csr_pkg::MSTATUS_MIE_BIT]  = 1'b0;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      mcycle   <= '0;
      mstatus  <= csr_pkg::MSTATUS_RESET;
      mie      <= '0;
      mtvec    <= '0;
      mscratch <= '0;
      mepc     <= '0;
      mcause   <= '0;
      mip      <= '0;
    end else begin
      mcycle <= mcycle + csr_pkg::XLEN'(1);

      // a written mcycle replaces the increment
      if (i_wr_en) begin
        case (i_wr_idx)
          csr_pkg::CSR_IDX_MCYCLE:   mcycle   <= i_wr_data;
          csr_pkg::CSR_IDX_MSTATUS:  mstatus  <= mstatus_wr;
          csr_pkg::CSR_IDX_MIE:      mie      <= i_wr_data;
          csr_pkg::CSR_IDX_MTVEC:    mtvec    <= i_wr_data;
          csr_pkg::CSR_IDX_MSCRATCH: mscratch <= i_wr_data;
          csr_pkg::CSR_IDX_MEPC:     mepc     <= i_wr_data;
          csr_pkg::CSR_IDX_MCAUSE:   mcause   <= i_wr_data;
          csr_pkg::CSR_IDX_MIP:      mip      <= i_wr_data;
          default: ;
        endcase
      end

      // trap overrides any instruction write to the same register
      if (i_trap.valid) begin
        mepc    <= i_trap.pc;
        mcause  <= i_trap.cause;
        mstatus <= mstatus_trap;
      end
    end
  end

  assign o_trap_pc     = mtvec;
  assign o_mstatus_mie = mstatus[csr_pkg::MSTATUS_MIE_BIT];
  assign o_mie_mtie    = mie[csr_pkg::MIE_MTIE_BIT];

endmodule

// File: csr_unit.f
common/csr_pkg.sv
hw/csr_decode.sv
csr_file/csr_file.sv
hw/csr_execute.sv
hw/csr_result.sv
hw/csr_unit.sv
verification/csr_unit_tb.sv

// File: hw/csr_decode.sv
// csr_decode: funct3 and address decode into a registered operation
`timescale 1ns/1ns

module csr_decode (
  input  logic              clk,
  input  logic              rst,
  input  csr_pkg::csr_req_t i_req,
  output csr_pkg::csr_dec_t o_dec
);

  csr_pkg::csr_dec_t dec_d;

  always_comb begin
    dec_d       = '0;
    dec_d.valid = i_req.valid;
    dec_d.rd    = i_req.rd;

    case (i_req.funct3[1:0])
      2'd1: dec_d.op = csr_pkg::CSR_RW;
      2'd2: dec_d.op = csr_pkg::CSR_RS;
      2'd3: dec_d.op = csr_pkg::CSR_RC;
      default: begin
        dec_d.op      = csr_pkg::CSR_RW;
        dec_d.illegal = 1'b1;
      end
    endcase

    // immediate forms take the rs1 field itself
    if (i_req.funct3[2]) begin
      dec_d.operand = {{(csr_pkg::XLEN-5){1'b0}}, i_req.rs1};
    end else begin
      dec_d.operand = i_req.rs1_val;
    end

    case (i_req.addr)
      csr_pkg::CSR_ADDR_MCYCLE:   dec_d.idx = csr_pkg::CSR_IDX_MCYCLE;
      csr_pkg::CSR_ADDR_MSTATUS:  dec_d.idx = csr_pkg::CSR_IDX_MSTATUS;
      csr_pkg::CSR_ADDR_MIE:      dec_d.idx = csr_pkg::CSR_IDX_MIE;
      csr_pkg::CSR_ADDR_MTVEC:    dec_d.idx = csr_pkg::CSR_IDX_MTVEC;
      csr_pkg::CSR_ADDR_MSCRATCH: dec_d.idx = csr_pkg::CSR_IDX_MSCRATCH;
      csr_pkg::CSR_ADDR_MEPC:     dec_d.idx = csr_pkg::CSR_IDX_MEPC;
      csr_pkg::CSR_ADDR_MCAUSE:   dec_d.idx = csr_pkg::CSR_IDX_MCAUSE;
      csr_pkg::CSR_ADDR_MIP:      dec_d.idx = csr_pkg::CSR_IDX_MIP;
      default: begin
        dec_d.idx     = csr_pkg::CSR_IDX_NONE;
        dec_d.illegal = 1'b1;
      end
    endcase

    // set/clear with x0 or zero imm is read only
    dec_d.do_write = (dec_d.op == csr_pkg::CSR_RW) || (i_req.rs1 != 5'd0);
  end

  always_ff @(posedge clk) begin
    o_dec <= dec_d;
    if (rst) begin
      o_dec.valid <= 1'b0;
    end
  end

endmodule

// File: hw/csr_execute.sv
// csr_execute: read-modify-write of the addressed CSR and old-value writeback
`timescale 1ns/1ns

module csr_execute (
  input  csr_pkg::csr_dec_t        i_dec,
  output csr_pkg::csr_idx_e        o_rd_idx,
  input  logic [csr_pkg::XLEN-1:0] i_rd_data,
  output logic                     o_wr_en,
  output csr_pkg::csr_idx_e        o_wr_idx,
  output logic [csr_pkg::XLEN-1:0] o_wr_data,
  output csr_pkg::csr_wb_t         o_wb
);

  logic [csr_pkg::XLEN-1:0] new_val;

  // combinational read from the file
  assign o_rd_idx = i_dec.idx;

  always_comb begin
    case (i_dec.op)
      csr_pkg::CSR_RW: new_val = i_dec.operand;
      csr_pkg::CSR_RS: new_val = i_rd_data | i_dec.operand;
      csr_pkg::CSR_RC: new_val = i_rd_data & ~i_dec.operand;
      default:         new_val = i_dec.operand;
    endcase
  end

  assign o_wr_en   = i_dec.valid && i_dec.do_write && !i_dec.illegal;
  assign o_wr_idx  = i_dec.idx;
  assign o_wr_data = new_val;

  // rd gets the value before the update
  always_comb begin
    o_wb.valid   = i_dec.valid;
    o_wb.rd      = i_dec.rd;
    o_wb.illegal = i_dec.illegal;
    if (i_dec.illegal) begin
      o_wb.data = '0;
    end else begin
      o_wb.data = i_rd_data;
    end
  end

endmodule

// File: hw/csr_result.sv
// csr_result: registered writeback to the core
`timescale 1ns/1ns

module csr_result (
  input  logic             clk,
  input  logic             rst,
  input  csr_pkg::csr_wb_t i_wb,
  output csr_pkg::csr_wb_t o_wb
);

  // x0 results stay valid, the core drops them
  always_ff @(posedge clk) begin
    o_wb <= i_wb;
    if (rst) begin
      o_wb.valid <= 1'b0;
    end
  end

endmodule

// File: hw/csr_unit.sv
// csr_unit: top level joining decode, execute, result and the CSR file
`timescale 1ns/1ns

module csr_unit (
  input  logic                     clk,
  input  logic                     rst,
  input  csr_pkg::csr_req_t        i_req,
  input  csr_pkg::trap_t           i_trap,
  output csr_pkg::csr_wb_t         o_wb,
  output logic [csr_pkg::XLEN-1:0] o_trap_pc,
  output logic                     o_mstatus_mie,
  output logic                     o_mie_mtie
);

  csr_pkg::csr_dec_t        dec;
  csr_pkg::csr_wb_t         exe_wb;
  csr_pkg::csr_idx_e        rd_idx;
  csr_pkg::csr_idx_e        wr_idx;
  logic [csr_pkg::XLEN-1:0] rd_data;
  logic [csr_pkg::XLEN-1:0] wr_data;
  logic                     wr_en;

  csr_decode u_decode (
    .clk   (clk),
    .rst   (rst),
    .i_req (i_req),
    .o_dec (dec)
  );

  csr_execute u_execute (
    .i_dec     (dec),
    .o_rd_idx  (rd_idx),
    .i_rd_data (rd_data),
    .o_wr_en   (wr_en),
    .o_wr_idx  (wr_idx),
    .o_wr_data (wr_data),
    .o_wb      (exe_wb)
  );

  csr_file u_file (
    .clk           (clk),
    .rst           (rst),
    .i_rd_idx      (rd_idx),
    .o_rd_data     (rd_data),
    .i_wr_en       (wr_en),
    .i_wr_idx      (wr_idx),
    .i_wr_data     (wr_data),
    .i_trap        (i_trap),
    .o_trap_pc     (o_trap_pc),
    .o_mstatus_mie (o_mstatus_mie),
    .o_mie_mtie    (o_mie_mtie)
  );

  csr_result u_result (
    .clk  (clk),
    .rst  (rst),
    .i_wb (exe_wb),
    .o_wb (o_wb)
  );

endmodule

// File: run_sim.sh
#!/bin/sh
# builds the csr_unit testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module csr_unit_tb \
  -f csr_unit.f -o csr_unit_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/csr_unit_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^Test passed$" "$LOG"; then
  exit 0
fi
exit 1

// File: verification/csr_unit_tb.sv
// testbench for csr_unit with clock, reset, stimulus, reference model and writeback checks
`timescale 1ns/1ns

module csr_unit_tb;

  localparam int CLK_PERIOD  = 40;
  localparam int N_RAND      = 64;
  localparam int N_REQ       = N_RAND + 31;
  localparam int WATCHDOG_NS = (N_REQ + 20) * CLK_PERIOD * 4;

  logic              clk;
  logic              rst;
  csr_pkg::csr_req_t req;
  csr_pkg::trap_t    trap;
  csr_pkg::csr_wb_t  wb;
  logic [63:0]       trap_pc;
  logic              mstatus_mie;
  logic              mie_mtie;

  // reference registers with mcycle kept as an offset from edge_no
  logic [63:0] model_csr [8];
  logic [63:0] mc_off;
  logic [63:0] edge_no;

  string       test_name;
  string       exp_name [$];
  logic [4:0]  exp_rd [$];
  logic [63:0] exp_data [$];
  logic        exp_ill [$];
  logic [63:0] exp_due [$];

  integer seed;
  int     mismatches;
  int     other_errs;

  csr_unit DUT (
    .clk           (clk),
    .rst           (rst),
    .i_req         (req),
    .i_trap        (trap),
    .o_wb          (wb),
    .o_trap_pc     (trap_pc),
    .o_mstatus_mie (mstatus_mie),
    .o_mie_mtie    (mie_mtie)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // edges since reset counted like mcycle
  always @(posedge clk) begin
    if (rst) begin
      edge_no <= '0;
    end else begin
      edge_no <= edge_no + 64'd1;
    end
  end

  function automatic int csr_index(input logic [11:0] a);
    case (a)
      csr_pkg::CSR_ADDR_MCYCLE:   return 0;
      csr_pkg::CSR_ADDR_MSTATUS:  return 1;
      csr_pkg::CSR_ADDR_MIE:      return 2;
      csr_pkg::CSR_ADDR_MTVEC:    return 3;
      csr_pkg::CSR_ADDR_MSCRATCH: return 4;
      csr_pkg::CSR_ADDR_MEPC:     return 5;
      csr_pkg::CSR_ADDR_MCAUSE:   return 6;
      csr_pkg::CSR_ADDR_MIP:      return 7;
      default:                    return -1;
    endcase
  endfunction

  function automatic logic [11:0] csr_addr(input int i);
    case (i)
      0:       return csr_pkg::CSR_ADDR_MCYCLE;
      1:       return csr_pkg::CSR_ADDR_MSTATUS;
      2:       return csr_pkg::CSR_ADDR_MIE;
      3:       return csr_pkg::CSR_ADDR_MTVEC;
      4:       return csr_pkg::CSR_ADDR_MSCRATCH;
      5:       return csr_pkg::CSR_ADDR_MEPC;
      6:       return csr_pkg::CSR_ADDR_MCAUSE;
      default: return csr_pkg::CSR_ADDR_MIP;
    endcase
  endfunction

  // bit 63 (SD) is set when FS or XS is dirty
  function automatic logic [63:0] mstatus_written(input logic [63:0] v);
    logic sd;
    sd = (v[14:13] == 2'b11) || (v[16:15] == 2'b11);
    return {sd, v[62:0]};
  endfunction

  task automatic issue_csr(input logic [2:0] f3, input logic [4:0] rs1, input logic [63:0] val,
                           input logic [4:0] rd, input logic [11:0] addr);
    csr_pkg::csr_req_t r;
    logic [63:0]       cur;
    logic [63:0]       opnd;
    logic [63:0]       old;
    logic [63:0]       nv;
    int                idx;
    logic              legal;
    @(posedge clk);
    // edge_no has not counted this edge yet
    cur   = edge_no + 64'd1;
    idx   = csr_index(addr);
    legal = (f3[1:0] != 2'd0) && (idx >= 0);
    opnd  = f3[2] ? {59'd0, rs1} : val;
    if (idx == 0) begin
      old = cur + 64'd1 + mc_off;
    end else if (idx > 0) begin
      old = model_csr[idx];
    end else begin
      old = '0;
    end
    case (f3[1:0])
      2'd2:    nv = old | opnd;
      2'd3:    nv = old & ~opnd;
      default: nv = opnd;
    endcase
    if (legal && ((f3[1:0] == 2'd1) || (rs1 != 5'd0))) begin
      if (idx == 0) begin
        mc_off = nv - (cur + 64'd2);
      end else if (idx == 1) begin
        model_csr[1] = mstatus_written(nv);
      end else begin
        model_csr[idx] = nv;
      end
    end
    exp_name.push_back(test_name);
    exp_rd.push_back(rd);
    exp_data.push_back(legal ? old : 64'd0);
    exp_ill.push_back(!legal);
    exp_due.push_back(cur + 64'd2);
    r.valid   = 1'b1;
    r.funct3  = f3;
    r.rs1     = rs1;
    r.rs1_val = val;
    r.rd      = rd;
    r.addr    = addr;
    req <= r;
  endtask

  task automatic raise_trap(input logic [63:0] pc, input logic [63:0] cause);
    csr_pkg::trap_t t;
    t.valid = 1'b1;
    t.pc    = pc;
    t.cause = cause;
    @(posedge clk);
    trap <= t;
    model_csr[5] = pc;
    model_csr[6] = cause;
    model_csr[1][csr_pkg::MSTATUS_MPIE_BIT] = model_csr[1][csr_pkg::MSTATUS_MIE_BIT];
    model_csr[1][csr_pkg::MSTATUS_MIE_BIT]  = 1'b0;
    @(posedge clk);
    trap <= '0;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      req.valid <= 1'b0;
    end
  endtask

  task automatic drain_pipe;
    idle_cycles(1);
    while (exp_due.size() != 0) begin
      @(posedge clk);
    end
  endtask

  task automatic check_value(input string what, input logic [63:0] expv, input logic [63:0] act);
    assert (act === expv) else begin
      $display("Mismatch %s %s: expected %h, actual %h", test_name, what, expv, act);
      mismatches = mismatches + 1;
    end
  endtask

  task automatic pop_expected;
    void'(exp_name.pop_front());
    void'(exp_rd.pop_front());
    void'(exp_data.pop_front());
    void'(exp_ill.pop_front());
    void'(exp_due.pop_front());
  endtask

  // compare each writeback with the head of the expected queue
  always @(negedge clk) begin
    if (!rst) begin
      if (wb.valid) begin
        assert (exp_due.size() != 0) else begin
          $display("Unexpected writeback with nothing outstanding at %0t ns", $time);
          other_errs = other_errs + 1;
        end
        if (exp_due.size() != 0) begin
          assert (exp_due[0] == edge_no) else begin
            $display("Writeback for %s came at cycle %0d instead of cycle %0d",
                     exp_name[0], edge_no, exp_due[0]);
            other_errs = other_errs + 1;
          end
          assert (wb.data === exp_data[0]) else begin
            $display("Mismatch %s data: expected %h, actual %h",
                     exp_name[0], exp_data[0], wb.data);
            mismatches = mismatches + 1;
          end
          assert (wb.rd === exp_rd[0]) else begin
            $display("Mismatch %s rd: expected %0d, actual %0d", exp_name[0], exp_rd[0], wb.rd);
            mismatches = mismatches + 1;
          end
          assert (wb.illegal === exp_ill[0]) else begin
            $display("Mismatch %s illegal: expected %0b, actual %0b",
                     exp_name[0], exp_ill[0], wb.illegal);
            mismatches = mismatches + 1;
          end
          pop_expected();
        end
      end else if (exp_due.size() != 0) begin
        assert (exp_due[0] > edge_no) else begin
          $display("No writeback for %s two cycles after its issue", exp_name[0]);
          other_errs = other_errs + 1;
        end
        if (exp_due[0] <= edge_no) begin
          pop_expected();
        end
      end
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: writebacks still outstanding after %0d ns", WATCHDOG_NS);
    $display("Test failed");
    $finish;
  end

  initial begin
    int         pick;
    logic [2:0] f3;
    seed       = 95;
    mismatches = 0;
    other_errs = 0;
    mc_off     = '0;
    for (int i = 0; i < 8; i++) begin
      model_csr[i] = '0;
    end
    // MPP = machine mode
    model_csr[1] = 64'h1800;
    rst  = 1'b1;
    req  = '0;
    trap = '0;
    repeat (5) @(posedge clk);
    rst <= 1'b0;

    test_name = "reset_reads";
    for (int i = 0; i < 8; i++) begin
      issue_csr(3'd2, 5'd0, 64'd0, 5'(i + 1), csr_addr(i));
    end
    drain_pipe();
    @(negedge clk);
    check_value("o_mstatus_mie", 64'd0, mstatus_mie);
    check_value("o_mie_mtie", 64'd0, mie_mtie);

    test_name = "random_ops";
    for (int i = 0; i < N_RAND; i++) begin
      pick = $unsigned($random(seed)) % 6;
      f3   = (pick < 3) ? 3'(pick + 1) : 3'(pick + 2);
      issue_csr(f3, 5'($random(seed)), {$random(seed), $random(seed)}, 5'($random(seed)),
                csr_addr($unsigned($random(seed)) % 8));
    end
    drain_pipe();

    test_name = "no_write_illegal";
    issue_csr(3'd1, 5'd3, 64'h0123_4567_89ab_cdef, 5'd1, csr_pkg::CSR_ADDR_MSCRATCH);
    issue_csr(3'd2, 5'd0, 64'hffff_ffff_ffff_ffff, 5'd2, csr_pkg::CSR_ADDR_MSCRATCH);
    issue_csr(3'd3, 5'd0, 64'hffff_ffff_ffff_ffff, 5'd3, csr_pkg::CSR_ADDR_MSCRATCH);
    issue_csr(3'd7, 5'd0, 64'd0, 5'd4, csr_pkg::CSR_ADDR_MSCRATCH);
    issue_csr(3'd1, 5'd9, 64'hdead, 5'd5, 12'h7c0);
    issue_csr(3'd0, 5'd9, 64'hbeef, 5'd6, csr_pkg::CSR_ADDR_MSCRATCH);
    issue_csr(3'd2, 5'd0, 64'd0, 5'd7, csr_pkg::CSR_ADDR_MSCRATCH);
    drain_pipe();

    test_name = "mstatus_sd_enables";
    issue_csr(3'd1, 5'd1, 64'h7800, 5'd1, csr_pkg::CSR_ADDR_MSTATUS);
    issue_csr(3'd1, 5'd1, 64'h1_9800, 5'd2, csr_pkg::CSR_ADDR_MSTATUS);
    issue_csr(3'd1, 5'd1, 64'h8000_0000_0000_1800, 5'd3, csr_pkg::CSR_ADDR_MSTATUS);
    issue_csr(3'd6, 5'd8, 64'd0, 5'd4, csr_pkg::CSR_ADDR_MSTATUS);
    // only MTIE is left set in mie
    issue_csr(3'd1, 5'd4, 64'h80, 5'd5, csr_pkg::CSR_ADDR_MIE);
    issue_csr(3'd2, 5'd0, 64'd0, 5'd6, csr_pkg::CSR_ADDR_MSTATUS);
    issue_csr(3'd2, 5'd0, 64'd0, 5'd7, csr_pkg::CSR_ADDR_MIE);
    drain_pipe();
    @(negedge clk);
    check_value("o_mstatus_mie", 64'd1, mstatus_mie);
    check_value("o_mie_mtie", 64'd1, mie_mtie);

    test_name = "mcycle";
    issue_csr(3'd2, 5'd0, 64'd0, 5'd1, csr_pkg::CSR_ADDR_MCYCLE);
    idle_cycles(4);
    issue_csr(3'd2, 5'd0, 64'd0, 5'd2, csr_pkg::CSR_ADDR_MCYCLE);
    issue_csr(3'd1, 5'd1, {$random(seed), $random(seed)}, 5'd3, csr_pkg::CSR_ADDR_MCYCLE);
    idle_cycles(6);
    issue_csr(3'd2, 5'd0, 64'd0, 5'd4, csr_pkg::CSR_ADDR_MCYCLE);
    drain_pipe();

    test_name = "trap";
    issue_csr(3'd1, 5'd1, 64'h8000_4000, 5'd1, csr_pkg::CSR_ADDR_MTVEC);
    issue_csr(3'd6, 5'd8, 64'd0, 5'd2, csr_pkg::CSR_ADDR_MSTATUS);
    drain_pipe();
    raise_trap(64'h8000_1234, 64'h8000_0000_0000_0007);
    issue_csr(3'd2, 5'd0, 64'd0, 5'd3, csr_pkg::CSR_ADDR_MEPC);
    issue_csr(3'd2, 5'd0, 64'd0, 5'd4, csr_pkg::CSR_ADDR_MCAUSE);
    issue_csr(3'd2, 5'd0, 64'd0, 5'd5, csr_pkg::CSR_ADDR_MSTATUS);
    drain_pipe();
    @(negedge clk);
    check_value("o_trap_pc", model_csr[3], trap_pc);
    check_value("o_mstatus_mie", 64'd0, mstatus_mie);

    $display("Errors: %0d mismatches, %0d other failures", mismatches, other_errs);
    if ((mismatches == 0) && (other_errs == 0)) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule
